// ==== project.f ====
design/decim_pkg.sv
design/tap_ram.sv
design/decim_sequencer.sv
design/iq_mac.sv
design/round_clip.sv
design/decim_fir_iq.sv
verif/tb_decim_fir_iq.sv

// ==== Makefile ====
# Verilator build and run for the decimating complex FIR filter

VERILATOR ?= verilator
TOP       ?= tb_decim_fir_iq
RTL_TOP   ?= decim_fir_iq
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" $(LOG); then echo "Simulation ended early"; exit 1; fi

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) \
		design/decim_pkg.sv design/tap_ram.sv design/decim_sequencer.sv \
		design/iq_mac.sv design/round_clip.sv design/decim_fir_iq.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/tb_decim_fir_iq.sv ====
// Testbench for the decimating complex FIR filter
// Table-driven phases, each checked against a reference model of the filter

`timescale 1ns/1ns

module tb_decim_fir_iq;

	// Same values as the DUT defaults
	localparam int NDOWN   = 4;
	localparam int NCOEFFS = 23;
	localparam int SHIFT   = 2;
	// Fraction bits below the output LSB
	localparam int DROP    = decim_pkg::AW - decim_pkg::OW - SHIFT;
	localparam int NROWS   = 6;
	// Cycles allowed for the last results of a phase
	localparam int RESULT_TIMEOUT = 200;

	typedef enum int {COEF_RAMP, COEF_IMPULSE, COEF_LARGE, COEF_RANDOM} coeff_set_e;
	typedef enum int {SAMP_IMPULSE, SAMP_RANDOM, SAMP_FS_POS, SAMP_FS_NEG} sample_mode_e;

	typedef struct {
		string        name;
		coeff_set_e   cset;
		sample_mode_e smode;
		int           count;
	} phase_t;

	logic                  i_clk;
	logic                  i_reset;
	logic                  i_wr_coeff;
	decim_pkg::coeff_t     i_coeff;
	logic                  i_ce;
	decim_pkg::iq_sample_t i_sample;
	logic                  o_valid;
	decim_pkg::iq_result_t o_result;

	phase_t                rows [NROWS];
	decim_pkg::coeff_t     coef [NCOEFFS];
	// Every sample of the phase, x[j] at index j
	decim_pkg::iq_sample_t hist [$];
	// One entry per trigger: due cycle, checked flag, expected value
	int                    exp_due [$];
	logic                  exp_chk [$];
	decim_pkg::iq_result_t exp_val [$];
	logic [31:0]           rng_state = 32'd38;
	string                 phase_name = "idle";
	int                    cyc = 0;
	int                    valid_count = 0;
	int                    error_count = 0;

	decim_fir_iq i_decim_fir_iq (
		.i_clk      (i_clk),
		.i_reset    (i_reset),
		.i_wr_coeff (i_wr_coeff),
		.i_coeff    (i_coeff),
		.i_ce       (i_ce),
		.i_sample   (i_sample),
		.o_valid    (o_valid),
		.o_result   (o_result)
	);

	initial
	begin
		i_clk = 1'b0;
		forever #4 i_clk = ~i_clk;
	end

	// Rising edges seen so far
	always @(posedge i_clk)
	begin
		cyc <= cyc + 1;
	end

	// Outputs are sampled on the falling edge, away from the DUT updates
	always @(negedge i_clk)
	begin
		if (o_valid === 1'b1)
			take_result();
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		begin
			x = s;
			x = x ^ (x << 13);
			x = x ^ (x >> 17);
			x = x ^ (x << 5);
			return x;
		end
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic decim_pkg::coeff_t coeff_value(input coeff_set_e cset, input int k);
		logic [31:0] rnd;
		begin
			case (cset)
				// Odd and even, both signs
				COEF_RAMP:    return decim_pkg::coeff_t'(3 * k - 31);
				COEF_IMPULSE: return (k == 0) ? 12'sd1024 : 12'sd0;
				COEF_LARGE:   return 12'sd2047;
				default:
				begin
					rnd = next_random();
					return rnd[decim_pkg::CW-1:0];
				end
			endcase
		end
	endfunction

	function automatic decim_pkg::iq_sample_t sample_value(input sample_mode_e smode, input int j);
		decim_pkg::iq_sample_t x;
		begin
			x = '0;
			case (smode)
				// Period 25 walks the impulse across all trigger phases
				// An amplitude of 768 puts odd taps exactly on a rounding tie
				SAMP_IMPULSE:
				begin
					if (j % 25 == 24)
					begin
						x.i = 16'sd768;
						x.q = -16'sd768;
					end
				end
				SAMP_RANDOM: x = next_random();
				SAMP_FS_POS:
				begin
					x.i = 16'h7FFF;
					x.q = 16'h7FFF;
				end
				default:
				begin
					x.i = 16'h8000;
					x.q = 16'h8000;
				end
			endcase
			return x;
		end
	endfunction

	// Divide by 2^DROP, round half to even, clamp to the signed output range
	function automatic logic [decim_pkg::OW-1:0] expected_channel(input longint acc);
		longint q;
		longint r;
		longint half;
		longint hi;
		longint lo;
		begin
			q = acc >>> DROP;
			r = acc - (q <<< DROP);
			half = longint'(1) <<< (DROP - 1);
			if ((r > half) || ((r == half) && q[0]))
				q = q + 1;
			hi = (longint'(1) <<< (decim_pkg::OW - 1)) - 1;
			lo = -(longint'(1) <<< (decim_pkg::OW - 1));
			if (q > hi)
				q = hi;
			else if (q < lo)
				q = lo;
			return q[decim_pkg::OW-1:0];
		end
	endfunction

	// y[j] = sum of h[k] * x[j-k], one channel at a time
	function automatic decim_pkg::iq_result_t model_output(input int j);
		longint acc_i;
		longint acc_q;
		int     k;
		decim_pkg::iq_result_t y;
		begin
			acc_i = 0;
			acc_q = 0;
			for (k = 0; k < NCOEFFS; k++)
			begin
				acc_i += longint'(coef[k]) * longint'(hist[j-k].i);
				acc_q += longint'(coef[k]) * longint'(hist[j-k].q);
			end
			y.i = expected_channel(acc_i);
			y.q = expected_channel(acc_q);
			return y;
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	task automatic abort_run(input string why);
		error_count++;
		$display("TEST FAILED");
		$fatal(1, "%s", why);
	endtask

	task automatic check_result(input string name, input decim_pkg::iq_result_t exp,
		input decim_pkg::iq_result_t act);
		if (act !== exp)
		begin
			$display("FAIL %s: expected i=%0d q=%0d, actual i=%0d q=%0d",
				name, exp.i, exp.q, act.i, act.q);
			abort_run("filter output differs from the reference model");
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp)
		begin
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
			abort_run("count or cycle number differs from the expected value");
		end
	endtask

	// One o_valid pulse: match it to the oldest outstanding run
	task automatic take_result();
		int                    due;
		logic                  chk;
		decim_pkg::iq_result_t value;
		begin
			if (exp_due.size() == 0)
				abort_run("o_valid pulsed with no filter run outstanding");
			else
			begin
				due = exp_due.pop_front();
				chk = exp_chk.pop_front();
				value = exp_val.pop_front();
				valid_count++;
				check_count({phase_name, " latency"}, due, cyc);
				if (chk)
					check_result(phase_name, value, o_result);
			end
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Phase sequence
	////////////////////////////////////////////////////////////////////////////

	task automatic idle_cycles(input int n);
		repeat (n) @(negedge i_clk);
	endtask

	task automatic pulse_reset();
		@(negedge i_clk);
		i_reset = 1'b1;
		i_ce = 1'b0;
		i_wr_coeff = 1'b0;
		exp_due.delete();
		exp_chk.delete();
		exp_val.delete();
		hist.delete();
		valid_count = 0;
		idle_cycles(4);
		i_reset = 1'b0;
	endtask

	// h[0] first, the pointer has just been reset
	task automatic load_coeffs(input coeff_set_e cset);
		int k;
		begin
			for (k = 0; k < NCOEFFS; k++)
			begin
				@(negedge i_clk);
				coef[k] = coeff_value(cset, k);
				i_wr_coeff = 1'b1;
				i_coeff = coef[k];
			end
			@(negedge i_clk);
			i_wr_coeff = 1'b0;
			i_coeff = '0;
		end
	endtask

	// One sample every 8 cycles, so triggers sit 32 cycles apart
	task automatic feed_samples(input phase_t row);
		int                    j;
		decim_pkg::iq_sample_t x;
		begin
			for (j = 0; j < row.count; j++)
			begin
				@(negedge i_clk);
				x = sample_value(row.smode, j);
				hist.push_back(x);
				i_ce = 1'b1;
				i_sample = x;
				if (j % NDOWN == 0)
				begin
					// Accepted at edge cyc+1, result seen NCOEFFS+3 edges later
					exp_due.push_back(cyc + NCOEFFS + 4);
					exp_chk.push_back(j >= NCOEFFS - 1);
					if (j >= NCOEFFS - 1)
						exp_val.push_back(model_output(j));
					else
						exp_val.push_back('0);
				end
				@(negedge i_clk);
				i_ce = 1'b0;
				i_sample = '0;
				idle_cycles(6);
			end
		end
	endtask

	task automatic finish_phase(input phase_t row);
		int n_trig;
		int waited;
		begin
			n_trig = (row.count + NDOWN - 1) / NDOWN;
			waited = 0;
			while ((valid_count < n_trig) && (waited < RESULT_TIMEOUT))
			begin
				@(negedge i_clk);
				waited++;
			end
			if (valid_count < n_trig)
				abort_run("timed out waiting for o_valid at the end of a phase");
			// Quiet time, any extra pulse shows up in the monitor
			idle_cycles(2 * NCOEFFS);
		end
	endtask

	task automatic run_phase(input phase_t row);
		phase_name = row.name;
		pulse_reset();
		load_coeffs(row.cset);
		feed_samples(row);
		finish_phase(row);
	endtask

	initial
	begin
		i_reset = 1'b1;
		i_wr_coeff = 1'b0;
		i_coeff = '0;
		i_ce = 1'b0;
		i_sample = '0;

		rows[0] = '{"impulse_ramp", COEF_RAMP, SAMP_IMPULSE, 120};
		rows[1] = '{"random_random", COEF_RANDOM, SAMP_RANDOM, 160};
		rows[2] = '{"delta_random", COEF_IMPULSE, SAMP_RANDOM, 64};
		// Largest sums of both signs the 23-tap filter can build
		rows[3] = '{"large_full_pos", COEF_LARGE, SAMP_FS_POS, 64};
		rows[4] = '{"large_full_neg", COEF_LARGE, SAMP_FS_NEG, 64};
		// Fresh reset and a new set after the large one
		rows[5] = '{"reload_ramp_random", COEF_RAMP, SAMP_RANDOM, 96};

		for (int r = 0; r < NROWS; r++)
			run_phase(rows[r]);

		if (error_count == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== design/decim_fir_iq.sv ====
// Decimating complex FIR filter, top level
// One shared multiplier per channel, coefficients loaded at run time,
// one I/Q result for every NDOWN input samples

`timescale 1ns/1ns

module decim_fir_iq #(
	// Decimation ratio
	parameter int NDOWN   = 4,
	// Tap count, no more than 2^LG_DEPTH - NDOWN
	parameter int NCOEFFS = 23,
	// Output gain shift
	parameter int SHIFT   = 2
) (
	input  logic                  i_clk,
	input  logic                  i_reset,
	// Coefficient load
	input  logic                  i_wr_coeff,
	input  decim_pkg::coeff_t     i_coeff,
	// Sample input
	input  logic                  i_ce,
	input  decim_pkg::iq_sample_t i_sample,
	// Filter output
	output logic                  o_valid,
	output decim_pkg::iq_result_t o_result
);

	decim_pkg::addr_t      sample_waddr;
	decim_pkg::addr_t      coeff_waddr;
	decim_pkg::addr_t      sample_raddr;
	decim_pkg::addr_t      coeff_raddr;
	decim_pkg::pipe_ctl_t  addr_ctl;
	decim_pkg::pipe_ctl_t  data_ctl;
	decim_pkg::iq_sample_t sample_rdata;
	decim_pkg::coeff_t     coeff_rdata;
	decim_pkg::iq_acc_t    acc;
	logic                  acc_done;

	decim_sequencer #(
		.NDOWN   (NDOWN),
		.NCOEFFS (NCOEFFS)
	) i_decim_sequencer (
		.i_clk          (i_clk),
		.i_reset        (i_reset),
		.i_ce           (i_ce),
		.i_wr_coeff     (i_wr_coeff),
		.o_sample_waddr (sample_waddr),
		.o_coeff_waddr  (coeff_waddr),
		.o_sample_raddr (sample_raddr),
		.o_coeff_raddr  (coeff_raddr),
		.o_ctl          (addr_ctl)
	);

	// Circular history of input samples
	tap_ram #(
		.T_WORD (decim_pkg::iq_sample_t)
	) i_sample_ram (
		.i_clk   (i_clk),
		.i_we    (i_ce),
		.i_waddr (sample_waddr),
		.i_wdata (i_sample),
		.i_raddr (sample_raddr),
		.o_rdata (sample_rdata)
	);

	tap_ram #(
		.T_WORD (decim_pkg::coeff_t)
	) i_coeff_ram (
		.i_clk   (i_clk),
		.i_we    (i_wr_coeff),
		.i_waddr (coeff_waddr),
		.i_wdata (i_coeff),
		.i_raddr (coeff_raddr),
		.o_rdata (coeff_rdata)
	);

	// Match the one-clock read latency
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			data_ctl <= '0;
		else
			data_ctl <= addr_ctl;
	end

	iq_mac #(
		.NCOEFFS (NCOEFFS)
	) i_iq_mac (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_sample (sample_rdata),
		.i_coeff  (coeff_rdata),
		.i_ctl    (data_ctl),
		.o_acc    (acc),
		.o_done   (acc_done)
	);

	round_clip #(
		.SHIFT (SHIFT)
	) i_round_clip (
		.i_clk    (i_clk),
		.i_reset  (i_reset),
		.i_acc    (acc),
		.i_done   (acc_done),
		.o_valid  (o_valid),
		.o_result (o_result)
	);

endmodule

// ==== design/round_clip.sv ====
// Output stage of the FIR
// Shift, round half to even, saturate to OW bits and register the result

`timescale 1ns/1ns

module round_clip #(
	parameter int SHIFT = 2
) (
	input  logic                  i_clk,
	input  logic                  i_reset,
	input  decim_pkg::iq_acc_t    i_acc,
	input  logic                  i_done,
	output logic                  o_valid,
	output decim_pkg::iq_result_t o_result
);

	localparam int AW = decim_pkg::AW;
	localparam int OW = decim_pkg::OW;
	// Fraction bits dropped below the output LSB, at least 2
	localparam int DROP = AW - OW - SHIFT;

	// One channel: rounded value, or the rail when it does not fit
	function automatic logic [OW-1:0] round_sat(input logic [AW-1:0] acc);
		logic        lsb;
		logic [AW:0] bias;
		logic [AW:0] sum;
		logic [SHIFT+1:0] top;
		logic        sgn;
		begin
			lsb = acc[DROP];
			// Just under half for an even LSB, exactly half for an odd one
			bias = (AW+1)'({lsb, {(DROP-1){~lsb}}});
			// One guard bit so the rounding add cannot wrap
			sum = {acc[AW-1], acc} + bias;
			sgn = sum[AW];
			// Bits above the output must all repeat the sign
			top = sum[AW:DROP+OW-1];
			if ((&top) || !(|top))
				round_sat = sum[DROP+OW-1:DROP];
			else if (sgn)
				round_sat = {1'b1, {(OW-1){1'b0}}};
			else
				round_sat = {1'b0, {(OW-1){1'b1}}};
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Output register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_valid <= 1'b0;
		else
			o_valid <= i_done;
	end

	// Held until the next run completes
	always_ff @(posedge i_clk)
	begin
		if (i_done)
		begin
			o_result.i <= round_sat(i_acc.i);
			o_result.q <= round_sat(i_acc.q);
		end
	end

endmodule

// ==== design/iq_mac.sv ====
// Shared complex-by-real multiply-accumulate
// One product per clock for I and Q, summed over the taps of a run

`timescale 1ns/1ns

module iq_mac #(
	parameter int NCOEFFS = 23
) (
	input  logic                  i_clk,
	input  logic                  i_reset,
	// Read data and the strobes aligned with it
	input  decim_pkg::iq_sample_t i_sample,
	input  decim_pkg::coeff_t     i_coeff,
	input  decim_pkg::pipe_ctl_t  i_ctl,
	// Sum of the run, valid while o_done is high
	output decim_pkg::iq_acc_t    o_acc,
	output logic                  o_done
);

	localparam int EXT = decim_pkg::AW - (decim_pkg::IW + decim_pkg::CW);
	localparam int PW  = decim_pkg::IW + decim_pkg::CW;

	decim_pkg::iq_product_t prod;
	decim_pkg::pipe_ctl_t   p_ctl;
	decim_pkg::iq_acc_t     acc;
	logic                   in_run;

	// Product stage, both channels share the coefficient
	always_ff @(posedge i_clk)
	begin
		prod.i <= i_sample.i * i_coeff;
		prod.q <= i_sample.q * i_coeff;
	end

	// Strobes follow the product
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			p_ctl <= '0;
		else
			p_ctl <= i_ctl;
	end

	// Set between the first and last taps of a run
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			in_run <= 1'b0;
		else if (p_ctl.last)
			in_run <= 1'b0;
		else if (p_ctl.first)
			in_run <= 1'b1;
	end

	// Load on the first tap, add sign-extended products after that
	always_ff @(posedge i_clk)
	begin
		if (p_ctl.first)
		begin
			acc.i <= {{EXT{prod.i[PW-1]}}, prod.i};
			acc.q <= {{EXT{prod.q[PW-1]}}, prod.q};
		end
		else if (in_run)
		begin
			acc.i <= acc.i + {{EXT{prod.i[PW-1]}}, prod.i};
			acc.q <= acc.q + {{EXT{prod.q[PW-1]}}, prod.q};
		end
	end

	// Done rises with the final sum in the accumulator
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_done <= 1'b0;
		else
			o_done <= p_ctl.last;
	end

	assign o_acc = acc;

	// Only a one-tap filter opens and closes a run in one slot
	a_first_last: assert property (@(posedge i_clk) disable iff (i_reset)
		(p_ctl.first && p_ctl.last) |-> (NCOEFFS == 1));

	// Runs never overlap inside the accumulator
	a_run_framing: assert property (@(posedge i_clk) disable iff (i_reset)
		(p_ctl.first |-> !in_run) and (p_ctl.last |-> (in_run || p_ctl.first)));

endmodule

// ==== design/decim_sequencer.sv ====
// Run control for the decimating FIR
// Keeps both write pointers and the decimation countdown, and on every
// trigger walks the sample memory backward and the coefficients forward

`timescale 1ns/1ns

module decim_sequencer #(
	parameter int NDOWN   = 4,
	parameter int NCOEFFS = 23
) (
	input  logic                  i_clk,
	input  logic                  i_reset,
	// Sample and coefficient write strobes
	input  logic                  i_ce,
	input  logic                  i_wr_coeff,
	// Write addresses
	output decim_pkg::addr_t      o_sample_waddr,
	output decim_pkg::addr_t      o_coeff_waddr,
	// Read addresses and the strobes that go with them
	output decim_pkg::addr_t      o_sample_raddr,
	output decim_pkg::addr_t      o_coeff_raddr,
	output decim_pkg::pipe_ctl_t  o_ctl
);

	// Countdown needs at least one bit even for NDOWN of 1
	localparam int CNT_W = (NDOWN > 1) ? $clog2(NDOWN) : 1;
	localparam logic [CNT_W-1:0] CNT_RELOAD = CNT_W'(NDOWN - 1);
	localparam decim_pkg::addr_t LAST_TAP = decim_pkg::addr_t'(NCOEFFS - 1);

	decim_pkg::addr_t sample_wptr;
	decim_pkg::addr_t coeff_wptr;
	decim_pkg::addr_t didx;
	decim_pkg::addr_t tidx;
	logic [CNT_W-1:0] countdown;
	logic             running;
	logic             trigger;
	logic             last_tap;

	////////////////////////////////////////////////////////////////////////////
	// Write pointers
	////////////////////////////////////////////////////////////////////////////

	// Circular sample pointer, one step per accepted sample
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			sample_wptr <= '0;
		else if (i_ce)
			sample_wptr <= sample_wptr + 1'b1;
	end

	// Coefficient pointer, h[0] is the first word after reset
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			coeff_wptr <= '0;
		else if (i_wr_coeff)
			coeff_wptr <= coeff_wptr + 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Decimation countdown
	////////////////////////////////////////////////////////////////////////////

	// Zero marks a trigger sample, so the first sample after reset is one
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			countdown <= '0;
		else if (i_ce)
		begin
			if (countdown == '0)
				countdown <= CNT_RELOAD;
			else
				countdown <= countdown - 1'b1;
		end
	end

	assign trigger  = i_ce && (countdown == '0);
	assign last_tap = running && (tidx == LAST_TAP);

	////////////////////////////////////////////////////////////////////////////
	// Run state
	////////////////////////////////////////////////////////////////////////////

	// A trigger on the last tap restarts at once
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			running <= 1'b0;
		else if (trigger)
			running <= 1'b1;
		else if (last_tap)
			running <= 1'b0;
	end

	// Newest sample first: start at the address being written right now
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			didx <= '0;
			tidx <= '0;
		end
		else if (trigger)
		begin
			didx <= sample_wptr;
			tidx <= '0;
		end
		else if (running)
		begin
			didx <= didx - 1'b1;
			tidx <= tidx + 1'b1;
		end
	end

	assign o_sample_waddr = sample_wptr;
	assign o_coeff_waddr  = coeff_wptr;
	assign o_sample_raddr = didx;
	assign o_coeff_raddr  = tidx;

	// Strobes line up with the addresses, not yet with the read data
	assign o_ctl.first = running && (tidx == '0);
	assign o_ctl.last  = last_tap;

	// Caller spacing rule: the next trigger waits for the last address
	a_trigger_spacing: assert property (@(posedge i_clk) disable iff (i_reset)
		trigger |-> (!running || last_tap))
		else $error("trigger sample arrived while a run was still issuing addresses");

endmodule

// ==== design/tap_ram.sv ====
// Tap memory for the FIR filter
// One write port, one read port with a registered output

`timescale 1ns/1ns

module tap_ram #(
	// Word type stored in the memory
	parameter type T_WORD = decim_pkg::iq_sample_t
) (
	input  logic              i_clk,
	// Write port
	input  logic              i_we,
	input  decim_pkg::addr_t  i_waddr,
	input  T_WORD             i_wdata,
	// Read port, data one clock after the address
	input  decim_pkg::addr_t  i_raddr,
	output T_WORD             o_rdata
);

	localparam int DEPTH = 1 << decim_pkg::LG_DEPTH;

	T_WORD mem [0:DEPTH-1];

	// Write side
	always_ff @(posedge i_clk)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
	end

	// Registered read
	// Same-address read during a write returns the old word
	always_ff @(posedge i_clk)
	begin
		o_rdata <= mem[i_raddr];
	end

endmodule

// ==== design/decim_pkg.sv ====
// Shared definitions for the decimating complex FIR filter
// Widths, memory depth and the packed I/Q payload structs

package decim_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths
	////////////////////////////////////////////////////////////////////////////

	// Sample width per channel
	localparam int IW = 16;
	// Coefficient width
	localparam int CW = 12;
	// Output width per channel
	localparam int OW = 24;
	// Log2 of the memory depth, also the bound on the tap count
	localparam int LG_DEPTH = 7;
	// Accumulator width, room for 2^LG_DEPTH full-scale products
	localparam int AW = IW + CW + LG_DEPTH;

	////////////////////////////////////////////////////////////////////////////
	// Types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [LG_DEPTH-1:0] addr_t;
	typedef logic signed [CW-1:0] coeff_t;

	typedef struct packed {
		logic signed [IW-1:0] i;
		logic signed [IW-1:0] q;
	} iq_sample_t;

	typedef struct packed {
		logic signed [IW+CW-1:0] i;
		logic signed [IW+CW-1:0] q;
	} iq_product_t;

	typedef struct packed {
		logic signed [AW-1:0] i;
		logic signed [AW-1:0] q;
	} iq_acc_t;

	typedef struct packed {
		logic signed [OW-1:0] i;
		logic signed [OW-1:0] q;
	} iq_result_t;

	// Strobes that ride along with one tap through the pipeline
	typedef struct packed {
		logic first;
		logic last;
	} pipe_ctl_t;

endpackage
